// ==== logic/vc_map_pkg.sv ====
// Channel mapping shared definitions
package vc_map_pkg;

    // Physical channel selector as carried in request headers
    // VA asks the platform, or this shim, to pick a channel
    typedef enum logic [1:0]
    {
        VA  = 2'd0,
        VL0 = 2'd1,
        VH0 = 2'd2,
        VH1 = 2'd3
    } t_vc;

    // Cache-line address width
    localparam int CL_ADDR_BITS = 42;
    typedef logic [CL_ADDR_BITS-1:0] t_cl_addr;

    // Multi-line request length
    // Its width also sets how many low line bits the hash ignores
    localparam int CL_NUM_BITS = 2;
    typedef logic [CL_NUM_BITS-1:0] t_cl_num;

    // Metadata tag returned with each response
    localparam int MDATA_BITS = 16;
    typedef logic [MDATA_BITS-1:0] t_mdata;

    // Write data word beside the c1 header
    localparam int DATA_BITS = 64;

    // Read request header, 63 bits
    typedef struct packed
    {
        t_cl_addr addr;
        t_vc      vc_sel;
        logic     map_va;
        t_cl_num  cl_len;
        t_mdata   mdata;
    } t_c0_req_hdr;

    // Write request header
    // Same fields as a read plus the start of packet flag
    typedef struct packed
    {
        t_cl_addr addr;
        t_vc      vc_sel;
        logic     map_va;
        t_cl_num  cl_len;
        logic     sop;
        t_mdata   mdata;
    } t_c1_req_hdr;

    // Response as it comes back from the platform
    typedef struct packed
    {
        t_mdata mdata;
        t_vc    vc;
    } t_rsp;

    // Hash is a plain CRC-32 over a 32-bit slice of the line address
    // Zero seed, MSB first, no reflection and no final inversion
    localparam int          HASH_BITS = 32;
    localparam logic [31:0] HASH_POLY = 32'h04C11DB7;

    // Low hash bits index a 64 entry channel table
    localparam int SLOT_BITS = 6;

    // Slot table split 16 VL0 : 24 VH0 : 24 VH1
    localparam logic [SLOT_BITS-1:0] SLOT_VL0_LAST = 6'd15;
    localparam logic [SLOT_BITS-1:0] SLOT_VH0_LAST = 6'd39;

    // CSR address map
    localparam int CSR_ADDR_BITS = 2;
    localparam int CSR_DATA_BITS = 32;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_CTRL    = 2'd0;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_CNT_VL0 = 2'd1;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_CNT_VH0 = 2'd2;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_CNT_VH1 = 2'd3;

    // Mapped request counter width
    localparam int CNT_BITS = 32;

endpackage

// ==== logic/req_chan_if.sv ====
// Request channel and status interfaces
`timescale 1ns/10ps

// One request channel toward the platform
// The header type differs between the read and the write channel
interface req_chan_if #(parameter type T_HDR = vc_map_pkg::t_c0_req_hdr);
    logic                             valid;
    T_HDR                             hdr;
    // Only the write channel carries a meaningful data word
    logic [vc_map_pkg::DATA_BITS-1:0] data;

    modport src  (output valid, output hdr, output data);
    modport sink (input valid, input hdr, input data);
endinterface

// Status and control between the shim and the CSR block
interface vc_map_stat_if;
    // Mapping enable from the control register
    logic            ctrl_enable;

    // Strobes mark requests whose VA channel was replaced
    logic            c0_mapped;
    vc_map_pkg::t_vc c0_vc;
    logic            c1_mapped;
    vc_map_pkg::t_vc c1_vc;

    modport shim
    (
        input  ctrl_enable,
        output c0_mapped, c0_vc, c1_mapped, c1_vc
    );
    modport csr
    (
        output ctrl_enable,
        input  c0_mapped, c0_vc, c1_mapped, c1_vc
    );
endinterface

// ==== logic/vc_hash.sv ====
// Address hash to physical channel
`timescale 1ns/10ps

module vc_hash
(
    input  vc_map_pkg::t_cl_addr addr,
    output vc_map_pkg::t_vc      vc
);

    // Serial CRC-32, unrolled by the loop into a pure XOR network
    function automatic logic [31:0] crc32(input logic [31:0] word);
        logic [31:0] crc;
        logic        fb;
        crc = '0;
        for (int i = vc_map_pkg::HASH_BITS - 1; i >= 0; i--)
        begin
            fb  = crc[31] ^ word[i];
            crc = {crc[30:0], 1'b0};
            if (fb)
            begin
                crc = crc ^ vc_map_pkg::HASH_POLY;
            end
        end
        return crc;
    endfunction

    logic [31:0]                      addr_slice;
    logic [31:0]                      addr_swizzle;
    logic [31:0]                      hash;
    logic [vc_map_pkg::SLOT_BITS-1:0] slot;

    // Skip the bits covered by multi-line requests
    // so every line of a group lands on one channel
    assign addr_slice = addr[vc_map_pkg::CL_NUM_BITS +: 32];

    // Bits 4 and 5 barely reach the low CRC bits, so trade them for high bits
    assign addr_swizzle = {addr_slice[29:4], addr_slice[31:30], addr_slice[3:0]};

    assign hash = crc32(addr_swizzle);
    assign slot = hash[vc_map_pkg::SLOT_BITS-1:0];

    // Slot order does not matter since slots are already hashed
    always_comb
    begin
        if (slot <= vc_map_pkg::SLOT_VL0_LAST)
            vc = vc_map_pkg::VL0;
        else if (slot <= vc_map_pkg::SLOT_VH0_LAST)
            vc = vc_map_pkg::VH0;
        else
            vc = vc_map_pkg::VH1;
    end

endmodule

// ==== logic/vc_map_csr.sv ====
// Mapping control and counters
`timescale 1ns/10ps

module vc_map_csr
(
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 csr_wr,
    input  logic                                 csr_rd,
    input  logic [vc_map_pkg::CSR_ADDR_BITS-1:0] csr_addr,
    input  logic [vc_map_pkg::CSR_DATA_BITS-1:0] csr_wdata,
    output logic [vc_map_pkg::CSR_DATA_BITS-1:0] csr_rdata,
    output logic                                 csr_rdata_valid,
    vc_map_stat_if.csr                           stat
);

    // Counter slot k tracks channel CNT_VC[k] and lives at CNT_ADDR[k]
    localparam int NUM_CNT = 3;
    localparam vc_map_pkg::t_vc CNT_VC [NUM_CNT] =
        '{vc_map_pkg::VL0, vc_map_pkg::VH0, vc_map_pkg::VH1};
    localparam logic [vc_map_pkg::CSR_ADDR_BITS-1:0] CNT_ADDR [NUM_CNT] =
        '{vc_map_pkg::CSR_CNT_VL0, vc_map_pkg::CSR_CNT_VH0, vc_map_pkg::CSR_CNT_VH1};

    logic                                 enable;
    logic [vc_map_pkg::CNT_BITS-1:0]      cnt [NUM_CNT];

    // Mapping comes out of reset enabled
    always_ff @(posedge clk)
    begin
        if (reset)
            enable <= 1'b1;
        else if (csr_wr && (csr_addr == vc_map_pkg::CSR_CTRL))
            enable <= csr_wdata[0];
    end

    assign stat.ctrl_enable = enable;

    for (genvar k = 0; k < NUM_CNT; k++)
    begin : g_cnt
        logic [1:0] inc;

        // Both request channels may map to the same channel in one cycle
        assign inc = 2'((stat.c0_mapped && (stat.c0_vc == CNT_VC[k]))) +
                     2'((stat.c1_mapped && (stat.c1_vc == CNT_VC[k])));

        // A write to the counter address clears it and wins over a bump
        always_ff @(posedge clk)
        begin
            if (reset)
                cnt[k] <= '0;
            else if (csr_wr && (csr_addr == CNT_ADDR[k]))
                cnt[k] <= '0;
            else
                cnt[k] <= cnt[k] + vc_map_pkg::CNT_BITS'(inc);
        end
    end

    // Read data is only meaningful while the valid pulse is high
    always_ff @(posedge clk)
    begin
        if (csr_rd)
        begin
            case (csr_addr)
                vc_map_pkg::CSR_CTRL:    csr_rdata <= {31'b0, enable};
                vc_map_pkg::CSR_CNT_VL0: csr_rdata <= cnt[0];
                vc_map_pkg::CSR_CNT_VH0: csr_rdata <= cnt[1];
                default:                 csr_rdata <= cnt[2];
            endcase
        end
    end

    // One cycle read latency
    always_ff @(posedge clk)
    begin
        if (reset)
            csr_rdata_valid <= 1'b0;
        else
            csr_rdata_valid <= csr_rd;
    end

endmodule

// ==== logic/vc_map_shim.sv ====
// VA channel mapping shim
`timescale 1ns/10ps

// Requests asking for any channel with map_va set get a concrete channel
// picked from their address, so one line always uses one channel and
// ordering within that channel keeps writes and later reads consistent
module vc_map_shim
(
    input  logic                clk,
    input  logic                reset,

    // Requests from the accelerator
    req_chan_if.sink            afu_c0,
    req_chan_if.sink            afu_c1,

    // Requests toward the platform
    req_chan_if.src             fiu_c0,
    req_chan_if.src             fiu_c1,

    vc_map_stat_if.shim         stat,

    // Back-pressure and responses flow the other way untouched
    input  logic [1:0]          fiu_alm_full,
    output logic [1:0]          afu_alm_full,
    input  logic                rx_in_valid,
    input  vc_map_pkg::t_rsp    rx_in,
    output logic                rx_out_valid,
    output vc_map_pkg::t_rsp    rx_out
);

    // Local copy of reset to ease fan-out, mapping starts one cycle late
    logic reset_q;

    always_ff @(posedge clk)
    begin
        reset_q <= reset;
    end

    logic            map_on;
    logic            c0_map;
    logic            c1_map;
    vc_map_pkg::t_vc c0_hash_vc;
    vc_map_pkg::t_vc c1_hash_vc;

    assign map_on = stat.ctrl_enable && !reset_q;

    // Each channel gets its own hash so both can map in the same cycle
    vc_hash u_c0_hash
    (
        .addr (afu_c0.hdr.addr),
        .vc   (c0_hash_vc)
    );

    vc_hash u_c1_hash
    (
        .addr (afu_c1.hdr.addr),
        .vc   (c1_hash_vc)
    );

    // Only VA requests that opt in are remapped
    assign c0_map = map_on && afu_c0.hdr.map_va && (afu_c0.hdr.vc_sel == vc_map_pkg::VA);
    assign c1_map = map_on && afu_c1.hdr.map_va && (afu_c1.hdr.vc_sel == vc_map_pkg::VA);

    // Read channel
    always_comb
    begin
        fiu_c0.valid   = afu_c0.valid;
        fiu_c0.hdr     = afu_c0.hdr;
        fiu_c0.data    = afu_c0.data;
        stat.c0_mapped = 1'b0;
        if (c0_map)
        begin
            fiu_c0.hdr.vc_sel = c0_hash_vc;
            stat.c0_mapped    = afu_c0.valid;
        end
    end

    // Write channel, the data word rides along unchanged
    always_comb
    begin
        fiu_c1.valid   = afu_c1.valid;
        fiu_c1.hdr     = afu_c1.hdr;
        fiu_c1.data    = afu_c1.data;
        stat.c1_mapped = 1'b0;
        if (c1_map)
        begin
            fiu_c1.hdr.vc_sel = c1_hash_vc;
            stat.c1_mapped    = afu_c1.valid;
        end
    end

    // The CSR block only looks at these while the strobe is high
    assign stat.c0_vc = c0_hash_vc;
    assign stat.c1_vc = c1_hash_vc;

    assign afu_alm_full = fiu_alm_full;
    assign rx_out_valid = rx_in_valid;
    assign rx_out       = rx_in;

endmodule

// ==== logic/vc_map_top.sv ====
// Channel mapping top level
`timescale 1ns/10ps

module vc_map_top
(
    input  logic                                 clk,
    input  logic                                 reset,

    // Accelerator side requests
    input  logic                                 afu_c0_valid,
    input  vc_map_pkg::t_c0_req_hdr              afu_c0_hdr,
    input  logic                                 afu_c1_valid,
    input  vc_map_pkg::t_c1_req_hdr              afu_c1_hdr,
    input  logic [vc_map_pkg::DATA_BITS-1:0]     afu_c1_data,

    // Platform side requests
    output logic                                 fiu_c0_valid,
    output vc_map_pkg::t_c0_req_hdr              fiu_c0_hdr,
    output logic                                 fiu_c1_valid,
    output vc_map_pkg::t_c1_req_hdr              fiu_c1_hdr,
    output logic [vc_map_pkg::DATA_BITS-1:0]     fiu_c1_data,

    // Almost-full flags
    input  logic                                 fiu_c0_alm_full,
    input  logic                                 fiu_c1_alm_full,
    output logic                                 afu_c0_alm_full,
    output logic                                 afu_c1_alm_full,

    // Responses
    input  logic                                 fiu_rx_valid,
    input  vc_map_pkg::t_rsp                     fiu_rx,
    output logic                                 afu_rx_valid,
    output vc_map_pkg::t_rsp                     afu_rx,

    // CSR access
    input  logic                                 csr_wr,
    input  logic                                 csr_rd,
    input  logic [vc_map_pkg::CSR_ADDR_BITS-1:0] csr_addr,
    input  logic [vc_map_pkg::CSR_DATA_BITS-1:0] csr_wdata,
    output logic [vc_map_pkg::CSR_DATA_BITS-1:0] csr_rdata,
    output logic                                 csr_rdata_valid
);

    req_chan_if #(.T_HDR(vc_map_pkg::t_c0_req_hdr)) afu_c0_if ();
    req_chan_if #(.T_HDR(vc_map_pkg::t_c1_req_hdr)) afu_c1_if ();
    req_chan_if #(.T_HDR(vc_map_pkg::t_c0_req_hdr)) fiu_c0_if ();
    req_chan_if #(.T_HDR(vc_map_pkg::t_c1_req_hdr)) fiu_c1_if ();
    vc_map_stat_if                                  stat_if ();

    logic [1:0] afu_alm_full;

    // Reads carry no data word
    assign afu_c0_if.valid = afu_c0_valid;
    assign afu_c0_if.hdr   = afu_c0_hdr;
    assign afu_c0_if.data  = '0;
    assign afu_c1_if.valid = afu_c1_valid;
    assign afu_c1_if.hdr   = afu_c1_hdr;
    assign afu_c1_if.data  = afu_c1_data;

    assign fiu_c0_valid = fiu_c0_if.valid;
    assign fiu_c0_hdr   = fiu_c0_if.hdr;
    assign fiu_c1_valid = fiu_c1_if.valid;
    assign fiu_c1_hdr   = fiu_c1_if.hdr;
    assign fiu_c1_data  = fiu_c1_if.data;

    assign afu_c0_alm_full = afu_alm_full[0];
    assign afu_c1_alm_full = afu_alm_full[1];

    vc_map_shim u_shim
    (
        .clk          (clk),
        .reset        (reset),
        .afu_c0       (afu_c0_if.sink),
        .afu_c1       (afu_c1_if.sink),
        .fiu_c0       (fiu_c0_if.src),
        .fiu_c1       (fiu_c1_if.src),
        .stat         (stat_if.shim),
        .fiu_alm_full ({fiu_c1_alm_full, fiu_c0_alm_full}),
        .afu_alm_full (afu_alm_full),
        .rx_in_valid  (fiu_rx_valid),
        .rx_in        (fiu_rx),
        .rx_out_valid (afu_rx_valid),
        .rx_out       (afu_rx)
    );

    vc_map_csr u_csr
    (
        .clk             (clk),
        .reset           (reset),
        .csr_wr          (csr_wr),
        .csr_rd          (csr_rd),
        .csr_addr        (csr_addr),
        .csr_wdata       (csr_wdata),
        .csr_rdata       (csr_rdata),
        .csr_rdata_valid (csr_rdata_valid),
        .stat            (stat_if.csr)
    );

endmodule

// ==== bench/vc_map_asserts.sv ====
// Channel mapping shim assertions
`timescale 1ns/10ps

module vc_map_asserts
(
    input logic            clk,
    input logic            reset,
    input logic            map_on,
    input logic            c0_in_valid,
    input logic            c1_in_valid,
    input logic            c0_out_valid,
    input logic            c1_out_valid,
    input logic            c0_out_map_va,
    input logic            c1_out_map_va,
    input vc_map_pkg::t_vc c0_out_vc,
    input vc_map_pkg::t_vc c1_out_vc,
    input logic            c0_mapped,
    input logic            c1_mapped
);

    // An opted-in VA request must leave with a concrete channel while mapping is on
    // The output header still carries map_va, so it stands in for the input flag
    a_c0_no_va: assert property (@(posedge clk) disable iff (reset)
        (c0_out_valid && map_on && c0_out_map_va) |-> (c0_out_vc != vc_map_pkg::VA))
        else $error("c0 request left on VA while mapping was enabled");
    a_c1_no_va: assert property (@(posedge clk) disable iff (reset)
        (c1_out_valid && map_on && c1_out_map_va) |-> (c1_out_vc != vc_map_pkg::VA))
        else $error("c1 request left on VA while mapping was enabled");

    // The shim neither drops nor invents requests
    a_c0_valid: assert property (@(posedge clk) disable iff (reset)
        c0_out_valid == c0_in_valid)
        else $error("c0 output valid differs from input valid");
    a_c1_valid: assert property (@(posedge clk) disable iff (reset)
        c1_out_valid == c1_in_valid)
        else $error("c1 output valid differs from input valid");

    // Counters must only see strobes for requests that really left
    a_c0_strobe: assert property (@(posedge clk) disable iff (reset)
        c0_mapped |-> c0_out_valid)
        else $error("c0 mapped strobe without an output request");
    a_c1_strobe: assert property (@(posedge clk) disable iff (reset)
        c1_mapped |-> c1_out_valid)
        else $error("c1 mapped strobe without an output request");

endmodule

// ==== bench/vc_map_tb.sv ====
// Channel mapping shim testbench
`timescale 1ns/10ps

module vc_map_tb;

    localparam int NUM_ROWS = 12;
    localparam int NUM_RAND = 40;
    // The table runs twice, plus the random pairs and room for reset and CSR traffic
    localparam int TIMEOUT_CYCLES = 2 * NUM_ROWS + NUM_RAND + 100;

    // One row drives one request channel for one cycle
    typedef struct packed
    {
        logic                 chan;
        logic                 valid;
        vc_map_pkg::t_cl_addr addr;
        vc_map_pkg::t_vc      vc_sel;
        logic                 map_va;
        vc_map_pkg::t_cl_num  cl_len;
        vc_map_pkg::t_mdata   mdata;
    } t_row;

    // Mixes VA with map_va, concrete channels, map_va clear and idle cycles
    localparam t_row ROWS [NUM_ROWS] = '{
        '{1'b0, 1'b1, 42'h000_1234_5600, vc_map_pkg::VA,  1'b1, 2'd0, 16'h0001},
        '{1'b1, 1'b1, 42'h0ab_cdef_0120, vc_map_pkg::VA,  1'b1, 2'd1, 16'h0002},
        '{1'b0, 1'b1, 42'h2f0_0000_1000, vc_map_pkg::VL0, 1'b1, 2'd0, 16'h0003},
        '{1'b1, 1'b1, 42'h100_0fff_ff00, vc_map_pkg::VH1, 1'b0, 2'd3, 16'h0004},
        '{1'b0, 1'b1, 42'h3ff_ffff_fffc, vc_map_pkg::VA,  1'b0, 2'd0, 16'h0005},
        '{1'b1, 1'b1, 42'h055_5555_5554, vc_map_pkg::VA,  1'b0, 2'd2, 16'h0006},
        '{1'b0, 1'b1, 42'h0c3_a5a5_0040, vc_map_pkg::VH0, 1'b1, 2'd1, 16'h0007},
        '{1'b0, 1'b0, 42'h111_2222_3330, vc_map_pkg::VA,  1'b1, 2'd0, 16'h0008},
        '{1'b1, 1'b1, 42'h001_0000_0010, vc_map_pkg::VA,  1'b1, 2'd3, 16'h0009},
        '{1'b0, 1'b1, 42'h200_8000_0004, vc_map_pkg::VA,  1'b1, 2'd0, 16'h000a},
        '{1'b1, 1'b1, 42'h07e_1357_9bd0, vc_map_pkg::VH0, 1'b0, 2'd0, 16'h000b},
        '{1'b1, 1'b0, 42'h3c0_0000_0000, vc_map_pkg::VA,  1'b1, 2'd1, 16'h000c}
    };

    logic                                 clk;
    logic                                 reset;
    logic                                 afu_c0_valid;
    vc_map_pkg::t_c0_req_hdr              afu_c0_hdr;
    logic                                 afu_c1_valid;
    vc_map_pkg::t_c1_req_hdr              afu_c1_hdr;
    logic [vc_map_pkg::DATA_BITS-1:0]     afu_c1_data;
    logic                                 fiu_c0_valid;
    vc_map_pkg::t_c0_req_hdr              fiu_c0_hdr;
    logic                                 fiu_c1_valid;
    vc_map_pkg::t_c1_req_hdr              fiu_c1_hdr;
    logic [vc_map_pkg::DATA_BITS-1:0]     fiu_c1_data;
    logic                                 fiu_c0_alm_full;
    logic                                 fiu_c1_alm_full;
    logic                                 afu_c0_alm_full;
    logic                                 afu_c1_alm_full;
    logic                                 fiu_rx_valid;
    vc_map_pkg::t_rsp                     fiu_rx;
    logic                                 afu_rx_valid;
    vc_map_pkg::t_rsp                     afu_rx;
    logic                                 csr_wr;
    logic                                 csr_rd;
    logic [vc_map_pkg::CSR_ADDR_BITS-1:0] csr_addr;
    logic [vc_map_pkg::CSR_DATA_BITS-1:0] csr_wdata;
    logic [vc_map_pkg::CSR_DATA_BITS-1:0] csr_rdata;
    logic                                 csr_rdata_valid;

    // Model of the mapping enable and of the mapped requests per channel, indexed by t_vc
    logic map_enabled;
    int   tally [4];
    int   check_count;
    int   error_count;
    int   cycle_count;

    vc_map_top u_dut (.*);

    // Shim checks ride along on the shim inside the DUT
    bind vc_map_shim vc_map_asserts u_asserts
    (
        .clk           (clk),
        .reset         (reset),
        .map_on        (map_on),
        .c0_in_valid   (afu_c0.valid),
        .c1_in_valid   (afu_c1.valid),
        .c0_out_valid  (fiu_c0.valid),
        .c1_out_valid  (fiu_c1.valid),
        .c0_out_map_va (fiu_c0.hdr.map_va),
        .c1_out_map_va (fiu_c1.hdr.map_va),
        .c0_out_vc     (fiu_c0.hdr.vc_sel),
        .c1_out_vc     (fiu_c1.hdr.vc_sel),
        .c0_mapped     (stat.c0_mapped),
        .c1_mapped     (stat.c1_mapped)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Expected channel with the CRC done as long division of msg * x^32 by the generator
    function automatic vc_map_pkg::t_vc ref_vc(input vc_map_pkg::t_cl_addr addr);
        logic [31:0] line;
        logic [31:0] msg;
        logic [63:0] rem;
        logic [5:0]  slot;
        line = addr[33:2];
        msg  = {line[29:4], line[31:30], line[3:0]};
        rem  = {msg, 32'h0};
        for (int i = 63; i >= 32; i--)
        begin
            if (rem[i])
            begin
                rem = rem ^ ({31'h0, 1'b1, vc_map_pkg::HASH_POLY} << (i - 32));
            end
        end
        slot = rem[5:0];
        // Sixteen VL0 slots, then 24 each for VH0 and VH1
        if (slot < 6'd16)
            return vc_map_pkg::VL0;
        else if (slot < 6'd40)
            return vc_map_pkg::VH0;
        else
            return vc_map_pkg::VH1;
    endfunction

    task automatic check_bit(input logic got, input logic exp, input string what);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("[FAIL] %0t %s: got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_c0_hdr(input vc_map_pkg::t_c0_req_hdr got,
                                input vc_map_pkg::t_c0_req_hdr exp, input string what);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("[FAIL] %0t %s: got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_c1_hdr(input vc_map_pkg::t_c1_req_hdr got,
                                input vc_map_pkg::t_c1_req_hdr exp, input string what);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("[FAIL] %0t %s: got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_data(input logic [vc_map_pkg::DATA_BITS-1:0] got,
                              input logic [vc_map_pkg::DATA_BITS-1:0] exp, input string what);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("[FAIL] %0t %s: got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_rsp(input vc_map_pkg::t_rsp got, input vc_map_pkg::t_rsp exp,
                             input string what);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("[FAIL] %0t %s: got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input logic [vc_map_pkg::CSR_DATA_BITS-1:0] got,
                              input logic [vc_map_pkg::CSR_DATA_BITS-1:0] exp,
                              input string what);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("[FAIL] %0t %s: got %h expected %h", $time, what, got, exp);
        end
    endtask

    // Outputs are combinational, so look a quarter period after the falling edge
    task automatic check_requests();
        vc_map_pkg::t_c0_req_hdr exp0;
        vc_map_pkg::t_c1_req_hdr exp1;
        #2;
        exp0 = afu_c0_hdr;
        exp1 = afu_c1_hdr;
        if (map_enabled && exp0.map_va && (exp0.vc_sel == vc_map_pkg::VA))
        begin
            exp0.vc_sel = ref_vc(exp0.addr);
            if (afu_c0_valid)
                tally[int'(exp0.vc_sel)]++;
        end
        if (map_enabled && exp1.map_va && (exp1.vc_sel == vc_map_pkg::VA))
        begin
            exp1.vc_sel = ref_vc(exp1.addr);
            if (afu_c1_valid)
                tally[int'(exp1.vc_sel)]++;
        end
        check_bit(fiu_c0_valid, afu_c0_valid, "c0 valid");
        check_bit(fiu_c1_valid, afu_c1_valid, "c1 valid");
        if (afu_c0_valid)
            check_c0_hdr(fiu_c0_hdr, exp0, "c0 header");
        if (afu_c1_valid)
        begin
            check_c1_hdr(fiu_c1_hdr, exp1, "c1 header");
            check_data(fiu_c1_data, afu_c1_data, "c1 data");
        end
    endtask

    task automatic apply_row(input t_row r);
        @(negedge clk);
        afu_c0_valid = 1'b0;
        afu_c1_valid = 1'b0;
        if (r.chan == 1'b0)
        begin
            afu_c0_valid = r.valid;
            afu_c0_hdr   = '{r.addr, r.vc_sel, r.map_va, r.cl_len, r.mdata};
        end
        else
        begin
            afu_c1_valid = r.valid;
            afu_c1_hdr   = '{r.addr, r.vc_sel, r.map_va, r.cl_len, 1'b1, r.mdata};
            afu_c1_data  = {~r.mdata, r.mdata, r.addr[31:0]};
        end
        check_requests();
    endtask

    task automatic csr_write(input logic [1:0] addr, input logic [31:0] data);
        @(negedge clk);
        afu_c0_valid = 1'b0;
        afu_c1_valid = 1'b0;
        csr_wr       = 1'b1;
        csr_addr     = addr;
        csr_wdata    = data;
        @(negedge clk);
        csr_wr = 1'b0;
    endtask

    // Read data must be valid exactly one cycle after the strobe
    // and the valid pulse of any earlier read must be over by then
    task automatic csr_read_check(input logic [1:0] addr, input logic [31:0] exp,
                                  input string what);
        @(negedge clk);
        check_bit(csr_rdata_valid, 1'b0, "csr read valid idle");
        afu_c0_valid = 1'b0;
        afu_c1_valid = 1'b0;
        csr_rd       = 1'b1;
        csr_addr     = addr;
        @(negedge clk);
        csr_rd = 1'b0;
        check_bit(csr_rdata_valid, 1'b1, "csr read valid");
        check_word(csr_rdata, exp, what);
    endtask

    task automatic check_passthrough(input logic [1:0] af, input vc_map_pkg::t_rsp rsp);
        @(negedge clk);
        fiu_c0_alm_full = af[0];
        fiu_c1_alm_full = af[1];
        fiu_rx_valid    = ^af;
        fiu_rx          = rsp;
        #2;
        check_bit(afu_c0_alm_full, af[0], "c0 almost full");
        check_bit(afu_c1_alm_full, af[1], "c1 almost full");
        check_bit(afu_rx_valid, ^af, "response valid");
        check_rsp(afu_rx, rsp, "response");
    endtask

    // Ends the run if the main sequence stalls
    initial
    begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    initial
    begin
        vc_map_pkg::t_cl_addr base;
        logic [31:0]          seed;
        logic [31:0]          r1;
        logic [31:0]          r2;
        seed            = 32'h05bc4ea5;
        check_count     = 0;
        error_count     = 0;
        map_enabled     = 1'b1;
        tally           = '{0, 0, 0, 0};
        reset           = 1'b1;
        afu_c0_valid    = 1'b0;
        afu_c0_hdr      = '0;
        afu_c1_valid    = 1'b0;
        afu_c1_hdr      = '0;
        afu_c1_data     = '0;
        fiu_c0_alm_full = 1'b0;
        fiu_c1_alm_full = 1'b0;
        fiu_rx_valid    = 1'b0;
        fiu_rx          = '0;
        csr_wr          = 1'b0;
        csr_rd          = 1'b0;
        csr_addr        = '0;
        csr_wdata       = '0;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        check_bit(csr_rdata_valid, 1'b0, "read valid after reset");
        // Reset is registered again inside the shim
        repeat (2) @(negedge clk);
        csr_read_check(vc_map_pkg::CSR_CTRL, 32'h1, "enable after reset");

        for (int i = 0; i < NUM_ROWS; i++)
            apply_row(ROWS[i]);

        // Both channels at once with random line addresses
        for (int i = 0; i < NUM_RAND; i++)
        begin
            r1   = xorshift32(seed);
            r2   = xorshift32(r1);
            seed = r2;
            @(negedge clk);
            afu_c0_valid = 1'b1;
            afu_c0_hdr   = '{{r1[9:0], r2}, vc_map_pkg::VA, r1[10] | r1[11], r1[13:12],
                             r1[31:16]};
            afu_c1_valid = 1'b1;
            afu_c1_hdr   = '{{r2[9:0], r1}, vc_map_pkg::VA, r2[10] | r2[11], r2[13:12],
                             1'b1, r2[31:16]};
            afu_c1_data  = {r1, r2};
            check_requests();
        end

        // The lines of one multi-line group share a channel
        seed = xorshift32(seed);
        base = {8'h0, seed, 2'b00};
        for (int j = 0; j < 4; j++)
        begin
            apply_row(t_row'{1'b0, 1'b1, base | 42'(j), vc_map_pkg::VA, 1'b1, 2'(j),
                             16'h3000 + 16'(j)});
            check_bit(fiu_c0_hdr.vc_sel == ref_vc(base), 1'b1, "line group channel");
        end

        // With mapping off VA requests must pass as VA
        csr_write(vc_map_pkg::CSR_CTRL, 32'h0);
        map_enabled = 1'b0;
        csr_read_check(vc_map_pkg::CSR_CTRL, 32'h0, "enable after clear");
        for (int i = 0; i < NUM_ROWS; i++)
            apply_row(ROWS[i]);
        csr_write(vc_map_pkg::CSR_CTRL, 32'h1);
        map_enabled = 1'b1;
        apply_row(ROWS[0]);
        apply_row(ROWS[1]);

        csr_read_check(vc_map_pkg::CSR_CNT_VL0, tally[1], "VL0 count");
        csr_read_check(vc_map_pkg::CSR_CNT_VH0, tally[2], "VH0 count");
        csr_read_check(vc_map_pkg::CSR_CNT_VH1, tally[3], "VH1 count");

        // Any write to a counter clears only that counter
        csr_write(vc_map_pkg::CSR_CNT_VH0, 32'hdead_beef);
        tally[2] = 0;
        csr_read_check(vc_map_pkg::CSR_CNT_VH0, tally[2], "VH0 count after clear");
        csr_read_check(vc_map_pkg::CSR_CNT_VL0, tally[1], "VL0 count kept");

        check_passthrough(2'b01, '{16'h1234, vc_map_pkg::VL0});
        check_passthrough(2'b10, '{16'hbeef, vc_map_pkg::VH1});
        check_passthrough(2'b11, '{16'h0f0f, vc_map_pkg::VA});
        check_passthrough(2'b00, '{16'h8001, vc_map_pkg::VH0});

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== compile.f ====
logic/vc_map_pkg.sv
logic/req_chan_if.sv
logic/vc_hash.sv
logic/vc_map_csr.sv
logic/vc_map_shim.sv
logic/vc_map_top.sv
bench/vc_map_asserts.sv
bench/vc_map_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the channel mapping testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f compile.f \
    --top-module vc_map_tb \
    -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vvc_map_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation finished without failures"
exit 0
